/* logic/uart_baud_gen.sv */
`timescale 1ns/1ps
`default_nettype none

`include "uart_link_params.svh"

module uart_baud_gen (
    input  wire  clk,
    input  wire  rst_n,
    output logic s_tick
);

    // Counter width, at least one bit
    localparam int CNT_W = (`UART_BAUD_DIV > 1) ? $clog2(`UART_BAUD_DIV) : 1;
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`UART_BAUD_DIV - 1);

    logic [CNT_W-1:0] cnt;

    // Free-running divider
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (cnt == CNT_LAST) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    // One-cycle tick on the last count
    assign s_tick = (cnt == CNT_LAST);

endmodule

`default_nettype wire

/* logic/uart_link_params.svh */
`ifndef UART_LINK_PARAMS_SVH
`define UART_LINK_PARAMS_SVH

//////////////////////////////////////////////////////////////////////
// Serial link constants
//////////////////////////////////////////////////////////////////////

// Clock cycles per oversampling tick
// Kept small so a frame is short in simulation
`define UART_BAUD_DIV 4

// Oversampling ticks per bit
`define UART_OVERSAMPLE 16

// Payload bits per frame
`define UART_DATA_BITS 8

// Bytes packed into one word, byte 0 in the low lane
`define UART_WORD_BYTES 4

`endif

/* logic/uart_link_pkg.sv */
`default_nettype none

`include "uart_link_params.svh"

package uart_link_pkg;

    // One frame payload
    typedef logic [`UART_DATA_BITS-1:0] byte_t;

    // Full word, lane n holds byte n
    typedef logic [`UART_DATA_BITS*`UART_WORD_BYTES-1:0] word_t;

    // Receiver FSM
    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    // Transmitter FSM
    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_t;

endpackage

`default_nettype wire

/* logic/uart_link_top.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_link_top (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire                       rx,
    output logic                      tx,
    input  wire uart_link_pkg::word_t word_in,
    input  wire                       tx_start,
    output uart_link_pkg::word_t      word_out,
    output logic                      word_valid,
    output logic                      frame_err,
    output logic                      tx_busy
);

    import uart_link_pkg::*;

    // Shared oversampling tick
    logic  s_tick;
    // Receive path
    byte_t rx_byte;
    logic  rx_done;
    // Transmit path
    byte_t tx_byte;
    logic  byte_start;
    logic  byte_done;

    uart_baud_gen u_baud (
        .clk    (clk),
        .rst_n  (rst_n),
        .s_tick (s_tick)
    );

    //////////////////////////////////////////////////////////////////////
    // Serial in to words
    //////////////////////////////////////////////////////////////////////

    uart_rx u_rx (
        .clk       (clk),
        .rst_n     (rst_n),
        .rx        (rx),
        .s_tick    (s_tick),
        .rx_byte   (rx_byte),
        .rx_done   (rx_done),
        .frame_err (frame_err)
    );

    word_assembler u_asm (
        .clk        (clk),
        .rst_n      (rst_n),
        .rx_byte    (rx_byte),
        .rx_done    (rx_done),
        .word_out   (word_out),
        .word_valid (word_valid)
    );

    //////////////////////////////////////////////////////////////////////
    // Words to serial out
    //////////////////////////////////////////////////////////////////////

    word_serializer u_ser (
        .clk        (clk),
        .rst_n      (rst_n),
        .word_in    (word_in),
        .tx_start   (tx_start),
        .byte_done  (byte_done),
        .tx_byte    (tx_byte),
        .byte_start (byte_start),
        .tx_busy    (tx_busy)
    );

    uart_tx u_tx (
        .clk        (clk),
        .rst_n      (rst_n),
        .s_tick     (s_tick),
        .byte_start (byte_start),
        .tx_byte    (tx_byte),
        .tx         (tx),
        .byte_done  (byte_done)
    );

endmodule

`default_nettype wire

/* logic/uart_rx.sv */
`timescale 1ns/1ps
`default_nettype none

`include "uart_link_params.svh"

module uart_rx (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  rx,
    input  wire                  s_tick,
    output uart_link_pkg::byte_t rx_byte,
    output logic                 rx_done,
    output logic                 frame_err
);

    import uart_link_pkg::*;

    localparam int TICK_W = $clog2(`UART_OVERSAMPLE);
    localparam int BIT_W  = $clog2(`UART_DATA_BITS);
    // Mid-bit is tick 8 of 16
    localparam logic [TICK_W-1:0] TICK_MID  = TICK_W'(`UART_OVERSAMPLE / 2 - 1);
    localparam logic [TICK_W-1:0] TICK_LAST = TICK_W'(`UART_OVERSAMPLE - 1);
    localparam logic [BIT_W-1:0]  BIT_LAST  = BIT_W'(`UART_DATA_BITS - 1);

    rx_state_t         state;
    logic              rx_meta;
    logic              rx_sync;
    logic [TICK_W-1:0] tick_cnt;
    logic [BIT_W-1:0]  bit_cnt;
    // Bad stop bit seen, wait for line to return high
    logic              stop_low;
    byte_t             shift_q;

    // Two-flop synchroniser, line idles high
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Receive FSM
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= RX_IDLE;
            tick_cnt  <= '0;
            bit_cnt   <= '0;
            stop_low  <= 1'b0;
            rx_done   <= 1'b0;
            frame_err <= 1'b0;
        end else begin
            // Strobes last one cycle
            rx_done   <= 1'b0;
            frame_err <= 1'b0;
            case (state)
                RX_IDLE: begin
                    if (!rx_sync) begin
                        state    <= RX_START;
                        tick_cnt <= '0;
                    end
                end
                RX_START: begin
                    if (s_tick) begin
                        if (tick_cnt == TICK_MID) begin
                            // Glitch if line is high again at mid-bit
                            tick_cnt <= '0;
                            bit_cnt  <= '0;
                            state    <= rx_sync ? RX_IDLE : RX_DATA;
                        end else begin
                            tick_cnt <= tick_cnt + 1'b1;
                        end
                    end
                end
                RX_DATA: begin
                    if (s_tick) begin
                        if (tick_cnt == TICK_LAST) begin
                            tick_cnt <= '0;
                            if (bit_cnt == BIT_LAST) begin
                                state <= RX_STOP;
                            end else begin
                                bit_cnt <= bit_cnt + 1'b1;
                            end
                        end else begin
                            tick_cnt <= tick_cnt + 1'b1;
                        end
                    end
                end
                RX_STOP: begin
                    if (stop_low) begin
                        if (rx_sync) begin
                            stop_low <= 1'b0;
                            state    <= RX_IDLE;
                        end
                    end else if (s_tick) begin
                        if (tick_cnt == TICK_LAST) begin
                            tick_cnt <= '0;
                            if (rx_sync) begin
                                rx_done <= 1'b1;
                                state   <= RX_IDLE;
                            end else begin
                                // Byte dropped, only the error is reported
                                frame_err <= 1'b1;
                                stop_low  <= 1'b1;
                            end
                        end else begin
                            tick_cnt <= tick_cnt + 1'b1;
                        end
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // LSB first, shift in from the top at mid-bit
    always_ff @(posedge clk) begin
        if (state == RX_DATA && s_tick && tick_cnt == TICK_LAST) begin
            shift_q <= {rx_sync, shift_q[`UART_DATA_BITS-1:1]};
        end
    end

    assign rx_byte = shift_q;

    // Strobes exclusive, and each matches the stop level seen three cycles back on rx
    a_rx_strobe: assert property (@(posedge clk) disable iff (!rst_n)
        (rx_done || frame_err) |-> !(rx_done && frame_err) && (rx_done == $past(rx, 3)));

endmodule

`default_nettype wire

/* logic/uart_tx.sv */
`timescale 1ns/1ps
`default_nettype none

`include "uart_link_params.svh"

module uart_tx (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  s_tick,
    input  wire                  byte_start,
    input  wire uart_link_pkg::byte_t tx_byte,
    output logic                 tx,
    output logic                 byte_done
);

    import uart_link_pkg::*;

    localparam int TICK_W = $clog2(`UART_OVERSAMPLE);
    localparam int BIT_W  = $clog2(`UART_DATA_BITS);
    localparam logic [TICK_W-1:0] TICK_LAST = TICK_W'(`UART_OVERSAMPLE - 1);
    localparam logic [BIT_W-1:0]  BIT_LAST  = BIT_W'(`UART_DATA_BITS - 1);

    tx_state_t         state;
    logic [TICK_W-1:0] tick_cnt;
    logic [BIT_W-1:0]  bit_cnt;
    byte_t             shift_q;

    //////////////////////////////////////////////////////////////////////
    // Frame FSM, tx is a registered output
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= TX_IDLE;
            tick_cnt  <= '0;
            bit_cnt   <= '0;
            tx        <= 1'b1;
            byte_done <= 1'b0;
        end else begin
            byte_done <= 1'b0;
            case (state)
                TX_IDLE: begin
                    tx <= 1'b1;
                    if (byte_start) begin
                        // Start bit goes out right away
                        state    <= TX_START;
                        tick_cnt <= '0;
                        tx       <= 1'b0;
                    end
                end
                TX_START: begin
                    if (s_tick) begin
                        if (tick_cnt == TICK_LAST) begin
                            tick_cnt <= '0;
                            bit_cnt  <= '0;
                            state    <= TX_DATA;
                            tx       <= shift_q[0];
                        end else begin
                            tick_cnt <= tick_cnt + 1'b1;
                        end
                    end
                end
                TX_DATA: begin
                    if (s_tick) begin
                        if (tick_cnt == TICK_LAST) begin
                            tick_cnt <= '0;
                            if (bit_cnt == BIT_LAST) begin
                                state <= TX_STOP;
                                tx    <= 1'b1;
                            end else begin
                                // Next bit sits at [1] before the shift
                                bit_cnt <= bit_cnt + 1'b1;
                                tx      <= shift_q[1];
                            end
                        end else begin
                            tick_cnt <= tick_cnt + 1'b1;
                        end
                    end
                end
                TX_STOP: begin
                    if (s_tick) begin
                        if (tick_cnt == TICK_LAST) begin
                            byte_done <= 1'b1;
                            state     <= TX_IDLE;
                        end else begin
                            tick_cnt <= tick_cnt + 1'b1;
                        end
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    // Payload latch and LSB-first shift
    always_ff @(posedge clk) begin
        if (state == TX_IDLE && byte_start) begin
            shift_q <= tx_byte;
        end else if (state == TX_DATA && s_tick && tick_cnt == TICK_LAST) begin
            shift_q <= shift_q >> 1;
        end
    end

    // Line must rest at mark level between frames
    a_tx_idle_high: assert property (@(posedge clk) disable iff (!rst_n)
        (state == TX_IDLE) |-> tx);

endmodule

`default_nettype wire

/* logic/word_assembler.sv */
`timescale 1ns/1ps
`default_nettype none

`include "uart_link_params.svh"

module word_assembler (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire uart_link_pkg::byte_t rx_byte,
    input  wire                       rx_done,
    output uart_link_pkg::word_t      word_out,
    output logic                      word_valid
);

    import uart_link_pkg::*;

    localparam int IDX_W = $clog2(`UART_WORD_BYTES);
    localparam logic [IDX_W-1:0] IDX_LAST = IDX_W'(`UART_WORD_BYTES - 1);

    // Lane of the next byte
    logic [IDX_W-1:0] idx;
    word_t            collect_q;
    word_t            next_word;

    // Collected lanes plus the incoming byte
    always_comb begin
        next_word = collect_q;
        next_word[idx*`UART_DATA_BITS +: `UART_DATA_BITS] = rx_byte;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            idx        <= '0;
            word_valid <= 1'b0;
        end else begin
            word_valid <= rx_done && (idx == IDX_LAST);
            if (rx_done) begin
                idx <= (idx == IDX_LAST) ? '0 : idx + 1'b1;
            end
        end
    end

    // Output word only changes when a full word lands
    always_ff @(posedge clk) begin
        if (rx_done) begin
            collect_q <= next_word;
            if (idx == IDX_LAST) begin
                word_out <= next_word;
            end
        end
    end

    // Valid follows the last byte, which lands in the top lane
    a_valid_after_byte: assert property (@(posedge clk) disable iff (!rst_n)
        word_valid |-> $past(rx_done) &&
            (word_out[`UART_DATA_BITS*`UART_WORD_BYTES-1 -: `UART_DATA_BITS]
             == $past(rx_byte)));

endmodule

`default_nettype wire

/* logic/word_serializer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "uart_link_params.svh"

module word_serializer (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire uart_link_pkg::word_t word_in,
    input  wire                       tx_start,
    input  wire                       byte_done,
    output uart_link_pkg::byte_t      tx_byte,
    output logic                      byte_start,
    output logic                      tx_busy
);

    import uart_link_pkg::*;

    localparam int IDX_W = $clog2(`UART_WORD_BYTES);
    localparam logic [IDX_W-1:0] IDX_LAST = IDX_W'(`UART_WORD_BYTES - 1);

    // Lane currently on the line
    logic [IDX_W-1:0] idx;
    word_t            shadow_q;

    //////////////////////////////////////////////////////////////////////
    // Byte sequencing
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            idx        <= '0;
            byte_start <= 1'b0;
            tx_busy    <= 1'b0;
        end else begin
            byte_start <= 1'b0;
            if (!tx_busy) begin
                // New word, lane 0 first
                if (tx_start) begin
                    idx        <= '0;
                    byte_start <= 1'b1;
                    tx_busy    <= 1'b1;
                end
            end else if (byte_done) begin
                if (idx == IDX_LAST) begin
                    tx_busy <= 1'b0;
                end else begin
                    idx        <= idx + 1'b1;
                    byte_start <= 1'b1;
                end
            end
        end
    end

    // Start while busy is dropped, word stays untouched
    always_ff @(posedge clk) begin
        if (tx_start && !tx_busy) begin
            shadow_q <= word_in;
        end
    end

    assign tx_byte = shadow_q[idx*`UART_DATA_BITS +: `UART_DATA_BITS];

    // No second byte until the transmitter reports the first one done
    a_one_in_flight: assert property (@(posedge clk) disable iff (!rst_n)
        byte_start |=> !byte_start throughout byte_done[->1]);

endmodule

`default_nettype wire

/* tb/uart_link_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "uart_link_params.svh"

module uart_link_tb;

    import uart_link_pkg::*;

    localparam int BIT_CYCLES   = `UART_OVERSAMPLE * `UART_BAUD_DIV;
    localparam int RESET_CYCLES = 10;
    localparam int RX_WORDS     = 20;
    localparam int TX_WORDS     = 8;
    // Receive, bad frame plus one word, transmit, ignored start, loopback
    localparam int NUM_FRAMES   = RX_WORDS * 4 + 5 + TX_WORDS * 4 + 4 + 4;
    localparam int CYCLE_LIMIT  = 2 * NUM_FRAMES * 10 * BIT_CYCLES + RESET_CYCLES;
    localparam int BUSY_LIMIT   = 5 * 10 * BIT_CYCLES;

    logic  clk;
    logic  rst_n;
    logic  rx_drv;
    logic  loop_en;
    wire   rx_line;
    logic  tx;
    word_t word_in;
    logic  tx_start;
    word_t word_out;
    logic  word_valid;
    logic  frame_err;
    logic  tx_busy;

    // Scoreboard state
    word_t exp_q[$];
    word_t exp_word;
    byte_t mon_q[$];
    int    value_errs;
    int    other_errs;
    int    words_seen;
    int    frames_seen;
    int    frame_errs_seen;
    int    cycle_cnt;
    logic [31:0] lcg_state;

    // Loopback path, tx fed straight back into rx
    assign rx_line = loop_en ? tx : rx_drv;

    uart_link_top u_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .rx         (rx_line),
        .tx         (tx),
        .word_in    (word_in),
        .tx_start   (tx_start),
        .word_out   (word_out),
        .word_valid (word_valid),
        .frame_err  (frame_err),
        .tx_busy    (tx_busy)
    );

    // 4 ns clock
    initial clk = 1'b0;
    always #2 clk = ~clk;

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic rand_byte(output byte_t b);
        lcg_state = lcg_step(lcg_state);
        // Upper bits have the longer period
        b = lcg_state[23:16];
    endtask

    // Expected word, byte 0 in the low lane
    function automatic word_t ref_word(input byte_t b0, input byte_t b1,
                                       input byte_t b2, input byte_t b3);
        word_t w;
        w = '0;
        w = w | (word_t'(b0) << 0);
        w = w | (word_t'(b1) << 8);
        w = w | (word_t'(b2) << 16);
        w = w | (word_t'(b3) << 24);
        return w;
    endfunction

    // Hold one bit level for a full bit time
    task automatic drive_bit(input logic v);
        rx_drv <= v;
        repeat (BIT_CYCLES) @(posedge clk);
    endtask

    // One frame onto rx, LSB first
    task automatic send_frame(input byte_t data, input logic stop_bit);
        drive_bit(1'b0);
        for (int i = 0; i < `UART_DATA_BITS; i++) begin
            drive_bit(data[i]);
        end
        drive_bit(stop_bit);
        rx_drv <= 1'b1;
    endtask

    // Four frames, then wait for the word
    task automatic receive_bytes(input byte_t b0, input byte_t b1,
                                 input byte_t b2, input byte_t b3);
        int target;
        int waited;
        exp_q.push_back(ref_word(b0, b1, b2, b3));
        target = words_seen + 1;
        send_frame(b0, 1'b1);
        send_frame(b1, 1'b1);
        send_frame(b2, 1'b1);
        send_frame(b3, 1'b1);
        waited = 0;
        while (words_seen < target && waited < 2 * BIT_CYCLES) begin
            @(negedge clk);
            waited++;
        end
        if (words_seen < target) begin
            $display("word_valid never arrived for received word %0d", target);
            other_errs++;
        end
        @(posedge clk);
    endtask

    // Send a word and check what the monitor decoded
    task automatic transmit_word(input word_t w, input logic try_restart);
        int    waited;
        word_t got;
        mon_q.delete();
        frames_seen = 0;
        word_in  <= w;
        tx_start <= 1'b1;
        @(posedge clk);
        tx_start <= 1'b0;
        @(negedge clk);
        if (tx_busy !== 1'b1) begin
            $display("tx_busy did not rise after tx_start");
            other_errs++;
        end
        if (try_restart) begin
            // Second start with another word while busy
            @(posedge clk);
            repeat (2 * BIT_CYCLES) @(posedge clk);
            word_in  <= ~w;
            tx_start <= 1'b1;
            @(posedge clk);
            tx_start <= 1'b0;
        end
        waited = 0;
        while (tx_busy === 1'b1 && waited < BUSY_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (tx_busy === 1'b1) begin
            $display("tx_busy never fell after the word was sent");
            other_errs++;
        end else if (frames_seen != `UART_WORD_BYTES) begin
            $display("[FAIL] %0t tx_busy fell after %0d frames", $time, frames_seen);
            value_errs++;
        end
        if (try_restart) begin
            repeat (2 * BIT_CYCLES) @(negedge clk);
            if (tx_busy !== 1'b0 || frames_seen != `UART_WORD_BYTES) begin
                $display("[FAIL] %0t ignored start produced traffic, %0d frames",
                         $time, frames_seen);
                value_errs++;
            end
        end
        if (mon_q.size() >= `UART_WORD_BYTES) begin
            got = ref_word(mon_q[0], mon_q[1], mon_q[2], mon_q[3]);
            if (got !== w) begin
                $display("[FAIL] %0t tx decoded %h expected %h", $time, got, w);
                value_errs++;
            end
        end
        @(posedge clk);
    endtask

    task automatic check_reset_state();
        if (tx !== 1'b1 || word_valid !== 1'b0 || frame_err !== 1'b0 ||
            tx_busy !== 1'b0) begin
            $display("[FAIL] %0t after reset tx=%b word_valid=%b frame_err=%b tx_busy=%b",
                     $time, tx, word_valid, frame_err, tx_busy);
            value_errs++;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Receive checker and tx monitor
    //////////////////////////////////////////////////////////////////////

    // Outputs sampled mid-cycle
    always @(negedge clk) begin
        if (rst_n && word_valid) begin
            words_seen = words_seen + 1;
            if (exp_q.size() == 0) begin
                $display("word_valid at %0t with no word pending", $time);
                other_errs++;
            end else begin
                exp_word = exp_q.pop_front();
                if (word_out !== exp_word) begin
                    $display("[FAIL] %0t word_out %h expected %h", $time, word_out, exp_word);
                    value_errs++;
                end
            end
        end
        if (rst_n && frame_err) begin
            frame_errs_seen = frame_errs_seen + 1;
        end
    end

    // Rebuild bytes from tx at mid-bit
    initial begin : tx_monitor
        byte_t mon_byte;
        forever begin
            @(negedge clk);
            if (rst_n && tx === 1'b0) begin
                repeat (BIT_CYCLES / 2) @(negedge clk);
                if (tx !== 1'b0) begin
                    $display("[FAIL] %0t start bit not low at mid-bit", $time);
                    value_errs++;
                end
                for (int i = 0; i < `UART_DATA_BITS; i++) begin
                    repeat (BIT_CYCLES) @(negedge clk);
                    mon_byte[i] = tx;
                end
                repeat (BIT_CYCLES) @(negedge clk);
                if (tx !== 1'b1) begin
                    $display("[FAIL] %0t stop bit not high", $time);
                    value_errs++;
                end
                mon_q.push_back(mon_byte);
                frames_seen = frames_seen + 1;
            end
        end
    end

    // Cycle limit
    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_cnt = cycle_cnt + 1;
        end
        $display("Run stopped at the cycle limit of %0d cycles", CYCLE_LIMIT);
        $display("TESTS FAILED");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        byte_t b0;
        byte_t b1;
        byte_t b2;
        byte_t b3;
        byte_t bad;
        int    errs_before;
        int    words_before;
        rst_n           = 1'b0;
        rx_drv          = 1'b1;
        loop_en         = 1'b0;
        tx_start        = 1'b0;
        word_in         = '0;
        lcg_state       = 32'd60477;
        value_errs      = 0;
        other_errs      = 0;
        words_seen      = 0;
        frames_seen     = 0;
        frame_errs_seen = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_reset_state();
        @(posedge clk);
        repeat (BIT_CYCLES) @(posedge clk);

        // Random words in over rx
        for (int n = 0; n < RX_WORDS; n++) begin
            rand_byte(b0);
            rand_byte(b1);
            rand_byte(b2);
            rand_byte(b3);
            receive_bytes(b0, b1, b2, b3);
        end

        // Bad stop bit, then line back to idle
        errs_before  = frame_errs_seen;
        words_before = words_seen;
        rand_byte(bad);
        send_frame(bad, 1'b0);
        drive_bit(1'b1);
        if (frame_errs_seen != errs_before + 1 || words_seen != words_before) begin
            $display("[FAIL] %0t framing error gave %0d frame_err and %0d words",
                     $time, frame_errs_seen - errs_before, words_seen - words_before);
            value_errs++;
        end
        rand_byte(b0);
        rand_byte(b1);
        rand_byte(b2);
        rand_byte(b3);
        receive_bytes(b0, b1, b2, b3);

        // Random words out over tx
        for (int n = 0; n < TX_WORDS; n++) begin
            rand_byte(b0);
            rand_byte(b1);
            rand_byte(b2);
            rand_byte(b3);
            transmit_word({b3, b2, b1, b0}, 1'b0);
        end

        // Start pulse while busy
        rand_byte(b0);
        rand_byte(b1);
        rand_byte(b2);
        rand_byte(b3);
        transmit_word({b3, b2, b1, b0}, 1'b1);

        // Loopback
        rand_byte(b0);
        rand_byte(b1);
        rand_byte(b2);
        rand_byte(b3);
        words_before = words_seen;
        loop_en <= 1'b1;
        exp_q.push_back({b3, b2, b1, b0});
        transmit_word({b3, b2, b1, b0}, 1'b0);
        repeat (2 * BIT_CYCLES) @(negedge clk);
        if (words_seen != words_before + 1) begin
            $display("word_valid never arrived for the looped back word");
            other_errs++;
        end
        @(posedge clk);
        loop_en <= 1'b0;
        repeat (BIT_CYCLES) @(posedge clk);

        if (exp_q.size() != 0) begin
            $display("%0d expected words never came out", exp_q.size());
            other_errs++;
        end
        if (frame_errs_seen != 1) begin
            $display("[FAIL] %0t frame_err pulsed %0d times", $time, frame_errs_seen);
            value_errs++;
        end

        $display("Errors: %0d wrong values, %0d other failures", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* uart_link.f */
+incdir+logic
logic/uart_link_pkg.sv
logic/uart_baud_gen.sv
logic/uart_rx.sv
logic/uart_tx.sv
logic/word_assembler.sv
logic/word_serializer.sv
logic/uart_link_top.sv
tb/uart_link_tb.sv
